// File: design/turf_pkg.sv
package turf_pkg;

    ////////////////////////////////////////
    // Bus and field widths
    ////////////////////////////////////////

    localparam int ADDR_W       = 28;
    localparam int DATA_W       = 32;
    // Slave-side address widths behind the decoder
    localparam int ID_ADDR_W    = 14;
    localparam int CRATE_ADDR_W = 27;
    // Remote address inside one link
    localparam int LINK_ADDR_W  = 25;
    localparam int NUM_LINKS    = 4;

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [LINK_ADDR_W-1:0] crate_addr_t;
    typedef logic [1:0]             link_sel_t;
    typedef logic [1:0]             bridge_type_t;

    ////////////////////////////////////////
    // Address map and register contents
    ////////////////////////////////////////

    // Top address bit picks the crate space
    localparam int CRATE_SEL_BIT = ADDR_W - 1;

    // Only type 1 is a working link bridge
    localparam bridge_type_t BRIDGE_TYPE_LINK = 2'd1;

    localparam data_t IDENT_WORD      = "TURF";
    localparam data_t BRIDGE_ERR_DATA = 32'hDEADDEAD;

    // ID space offsets
    localparam logic [ID_ADDR_W-1:0] ID_REG_IDENT       = 14'h0;
    localparam logic [ID_ADDR_W-1:0] ID_REG_DATEVER     = 14'h4;
    localparam logic [ID_ADDR_W-1:0] ID_REG_BRIDGE_TYPE = 14'h8;
    localparam logic [ID_ADDR_W-1:0] ID_REG_BRIDGE_STAT = 14'hC;

endpackage

// File: design/wb_if.sv
interface wb_if #(
    parameter int ADDR_WIDTH = 14
);
    import turf_pkg::*;

    // Classic WISHBONE cycle, single access in flight
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [ADDR_WIDTH-1:0] adr;
    // Write data, master to slave
    data_t                 dat_w;
    // Read data, slave to master
    data_t                 dat_r;
    // One cycle per access
    logic                  ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// File: design/baud_tick_gen.sv
module baud_tick_gen #(
    parameter int STEP  = 1,
    parameter int WIDTH = 8
) (
    input  logic ps_clk,
    input  logic arst_n_i,
    output logic tick_o
);

    // Carry bit on top of the fractional phase
    logic [WIDTH:0] acc_q;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // One step behind zero, so the wrap carry lands in the first window
            acc_q <= {1'b0, WIDTH'((2 ** WIDTH) - STEP)};
        end else begin
            acc_q <= {1'b0, acc_q[WIDTH-1:0]} + (WIDTH + 1)'(STEP);
        end
    end

    // High for one cycle per phase wrap
    assign tick_o = acc_q[WIDTH];

endmodule

// File: design/reg_intercon.sv
module reg_intercon (
    input  logic             ps_clk,
    input  logic             arst_n_i,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  turf_pkg::addr_t  wb_adr_i,
    input  turf_pkg::data_t  wb_dat_i,
    output turf_pkg::data_t  wb_dat_o,
    output logic             wb_ack_o,
    wb_if.master             id_m,
    wb_if.master             crate_m
);
    import turf_pkg::*;

    logic sel_crate;
    logic sel_id;
    logic sel_dummy;
    logic dummy_ack_q;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign sel_crate = wb_adr_i[CRATE_SEL_BIT];
    // ID space is the low 16 kB below the crate bit
    assign sel_id    = !sel_crate && (wb_adr_i[CRATE_SEL_BIT-1:ID_ADDR_W] == '0);
    // Holes in the map
    assign sel_dummy = !sel_crate && !sel_id;

    // ID control space
    assign id_m.cyc   = wb_cyc_i && sel_id;
    assign id_m.stb   = wb_stb_i && sel_id;
    assign id_m.we    = wb_we_i;
    assign id_m.adr   = wb_adr_i[ID_ADDR_W-1:0];
    assign id_m.dat_w = wb_dat_i;

    // Crate bridge space, link number stays in the address
    assign crate_m.cyc   = wb_cyc_i && sel_crate;
    assign crate_m.stb   = wb_stb_i && sel_crate;
    assign crate_m.we    = wb_we_i;
    assign crate_m.adr   = wb_adr_i[CRATE_ADDR_W-1:0];
    assign crate_m.dat_w = wb_dat_i;

    // Dummy slave, single-cycle ack pulse
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dummy_ack_q <= 1'b0;
        end else begin
            dummy_ack_q <= wb_cyc_i && wb_stb_i && sel_dummy && !dummy_ack_q;
        end
    end

    ////////////////////////////////////////
    // Response mux
    ////////////////////////////////////////

    always_comb begin
        if (sel_crate) begin
            wb_ack_o = crate_m.ack;
            wb_dat_o = crate_m.dat_r;
        end else if (sel_id) begin
            wb_ack_o = id_m.ack;
            wb_dat_o = id_m.dat_r;
        end else begin
            wb_ack_o = dummy_ack_q;
            // Unmapped reads return zero
            wb_dat_o = '0;
        end
    end

    // No target may answer outside a bus cycle
    a_ack_in_cycle: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i) wb_ack_o |-> wb_cyc_i
    ) else $error("reg_intercon: ack without cyc");

endmodule

// File: design/turf_id_ctrl.sv
module turf_id_ctrl #(
    parameter turf_pkg::data_t DATEVERSION = '0
) (
    input  logic                             ps_clk,
    input  logic                             arst_n_i,
    wb_if.slave                              bus,
    output logic [2*turf_pkg::NUM_LINKS-1:0] bridge_type_o,
    input  logic [turf_pkg::NUM_LINKS-1:0]   bridge_timeout_i,
    input  logic [turf_pkg::NUM_LINKS-1:0]   bridge_invalid_i
);
    import turf_pkg::*;

    logic                   ack_q;
    logic                   acc;
    logic                   wr;
    // Invalid flags in the upper half, timeouts in the lower
    logic [2*NUM_LINKS-1:0] stat_q;
    logic [2*NUM_LINKS-1:0] stat_clr;

    // New access, the ack cycle itself excluded
    assign acc = bus.cyc && bus.stb && !ack_q;
    assign wr  = acc && bus.we;

    // Write-one-to-clear mask
    assign stat_clr = (wr && (bus.adr == ID_REG_BRIDGE_STAT)) ?
                      bus.dat_w[2*NUM_LINKS-1:0] : '0;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q         <= 1'b0;
            bridge_type_o <= '0;
            stat_q        <= '0;
        end else begin
            ack_q <= acc;
            if (wr && (bus.adr == ID_REG_BRIDGE_TYPE)) begin
                bridge_type_o <= bus.dat_w[2*NUM_LINKS-1:0];
            end
            // New pulses win over a clear in the same cycle
            stat_q <= (stat_q & ~stat_clr) | {bridge_invalid_i, bridge_timeout_i};
        end
    end

    assign bus.ack = ack_q;

    // Read mux, address is held until ack
    always_comb begin
        case (bus.adr)
            ID_REG_IDENT:       bus.dat_r = IDENT_WORD;
            ID_REG_DATEVER:     bus.dat_r = DATEVERSION;
            ID_REG_BRIDGE_TYPE: bus.dat_r = {{(DATA_W-2*NUM_LINKS){1'b0}}, bridge_type_o};
            ID_REG_BRIDGE_STAT: bus.dat_r = {{(DATA_W-2*NUM_LINKS){1'b0}}, stat_q};
            default:            bus.dat_r = '0;
        endcase
    end

    // Held strobe must not produce a second ack
    a_single_ack: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i) bus.ack |=> !bus.ack
    ) else $error("turf_id_ctrl: ack held for two cycles");

endmodule

// File: design/crate_bridge.sv
module crate_bridge #(
    parameter int BRIDGE_TIMEOUT = 1024
) (
    input  logic                             ps_clk,
    input  logic                             arst_n_i,
    wb_if.slave                              bus,
    input  logic [2*turf_pkg::NUM_LINKS-1:0] bridge_type_i,
    input  logic [turf_pkg::NUM_LINKS-1:0]   link_up_i,
    output logic [turf_pkg::NUM_LINKS-1:0]   bridge_timeout_o,
    output logic [turf_pkg::NUM_LINKS-1:0]   bridge_invalid_o,
    output logic                             link_req_o,
    output turf_pkg::link_sel_t              link_sel_o,
    output turf_pkg::crate_addr_t            link_adr_o,
    output logic                             link_we_o,
    output turf_pkg::data_t                  link_dat_o,
    input  logic                             link_ack_i,
    input  turf_pkg::data_t                  link_dat_i
);
    import turf_pkg::*;

    localparam int TMR_W = $clog2(BRIDGE_TIMEOUT + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INVALID_ACK,
        ST_WAIT_LINK,
        ST_DONE
    } bridge_state_t;

    bridge_state_t    state_q;
    logic [TMR_W-1:0] tmr_q;
    data_t            rd_q;
    link_sel_t        acc_sel;
    bridge_type_t     acc_type;
    logic             acc_start;
    logic             acc_ok;
    logic             tmr_done;

    ////////////////////////////////////////
    // Access check
    ////////////////////////////////////////

    // Link number sits above the remote address
    assign acc_sel   = bus.adr[CRATE_ADDR_W-1:LINK_ADDR_W];
    assign acc_type  = bridge_type_i[2*acc_sel +: 2];
    // Needs a link bridge and a live link
    assign acc_ok    = (acc_type == BRIDGE_TYPE_LINK) && link_up_i[acc_sel];
    assign acc_start = bus.cyc && bus.stb && (state_q == ST_IDLE);
    assign tmr_done  = (tmr_q == TMR_W'(BRIDGE_TIMEOUT - 1));

    ////////////////////////////////////////
    // Bridge FSM
    ////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q          <= ST_IDLE;
            tmr_q            <= '0;
            link_req_o       <= 1'b0;
            bridge_timeout_o <= '0;
            bridge_invalid_o <= '0;
        end else begin
            // Request and flags are single-cycle pulses
            link_req_o       <= 1'b0;
            bridge_timeout_o <= '0;
            bridge_invalid_o <= '0;
            case (state_q)
                ST_IDLE: begin
                    tmr_q <= '0;
                    if (acc_start && acc_ok) begin
                        state_q    <= ST_WAIT_LINK;
                        link_req_o <= 1'b1;
                    end else if (acc_start) begin
                        state_q                   <= ST_INVALID_ACK;
                        bridge_invalid_o[acc_sel] <= 1'b1;
                    end
                end
                ST_WAIT_LINK: begin
                    if (link_ack_i) begin
                        state_q <= ST_DONE;
                    end else if (tmr_done) begin
                        // Remote side never answered
                        state_q                      <= ST_DONE;
                        bridge_timeout_o[link_sel_o] <= 1'b1;
                    end else begin
                        tmr_q <= tmr_q + 1'b1;
                    end
                end
                // Ack cycles, back to idle
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Link request fields and response data
    always_ff @(posedge ps_clk) begin
        if (acc_start) begin
            link_sel_o <= acc_sel;
            link_adr_o <= bus.adr[LINK_ADDR_W-1:0];
            link_we_o  <= bus.we;
            link_dat_o <= bus.dat_w;
        end
        if (acc_start && !acc_ok) begin
            rd_q <= BRIDGE_ERR_DATA;
        end else if (state_q == ST_WAIT_LINK && link_ack_i) begin
            rd_q <= link_dat_i;
        end else if (state_q == ST_WAIT_LINK && tmr_done) begin
            rd_q <= BRIDGE_ERR_DATA;
        end
    end

    assign bus.ack   = (state_q == ST_INVALID_ACK) || (state_q == ST_DONE);
    assign bus.dat_r = rd_q;

    // Request only on the step into the wait state
    a_req_on_start: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i)
        link_req_o |-> (state_q == ST_WAIT_LINK) && ($past(state_q) == ST_IDLE)
    ) else $error("crate_bridge: link request outside access start");

endmodule

// File: design/turf_regs_top.sv
module turf_regs_top #(
    parameter logic [3:0]  VER_MAJOR      = 4'd0,
    parameter logic [3:0]  VER_MINOR      = 4'd2,
    parameter logic [7:0]  VER_REV        = 8'd0,
    parameter logic [15:0] FIRMWARE_DATE  = 16'h0,
    parameter bit          REV_B          = 1'b0,
    parameter int          BRIDGE_TIMEOUT = 1024,
    parameter int          HSK_STEP       = 82,
    parameter int          HSK_WIDTH      = 10,
    parameter int          GPS_STEP       = 25,
    parameter int          GPS_WIDTH      = 12
) (
    input  logic                           ps_clk,
    input  logic                           arst_n_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  turf_pkg::addr_t                wb_adr_i,
    input  turf_pkg::data_t                wb_dat_i,
    output turf_pkg::data_t                wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           link_req_o,
    output turf_pkg::link_sel_t            link_sel_o,
    output turf_pkg::crate_addr_t          link_adr_o,
    output logic                           link_we_o,
    output turf_pkg::data_t                link_dat_o,
    input  logic                           link_ack_i,
    input  turf_pkg::data_t                link_dat_i,
    input  logic [turf_pkg::NUM_LINKS-1:0] link_up_i,
    output logic                           hsk_16x_o,
    output logic                           gps_16x_o
);
    import turf_pkg::*;

    // Board revision, 15-bit date, then major.minor.rev
    localparam data_t DATEVERSION = {REV_B, FIRMWARE_DATE[14:0],
                                     VER_MAJOR, VER_MINOR, VER_REV};

    ////////////////////////////////////////
    // Register spaces
    ////////////////////////////////////////

    wb_if #(.ADDR_WIDTH(ID_ADDR_W))    id_bus ();
    wb_if #(.ADDR_WIDTH(CRATE_ADDR_W)) crate_bus ();

    // Per-link bridge type, two bits each
    logic [2*NUM_LINKS-1:0] bridge_type;
    logic [NUM_LINKS-1:0]   bridge_timeout;
    logic [NUM_LINKS-1:0]   bridge_invalid;

    reg_intercon u_intercon (
        .ps_clk   (ps_clk),
        .arst_n_i (arst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .id_m     (id_bus),
        .crate_m  (crate_bus)
    );

    turf_id_ctrl #(.DATEVERSION(DATEVERSION)) u_idctrl (
        .ps_clk           (ps_clk),
        .arst_n_i         (arst_n_i),
        .bus              (id_bus),
        .bridge_type_o    (bridge_type),
        .bridge_timeout_i (bridge_timeout),
        .bridge_invalid_i (bridge_invalid)
    );

    // Crate accesses out to the remote links
    crate_bridge #(.BRIDGE_TIMEOUT(BRIDGE_TIMEOUT)) u_bridge (
        .ps_clk           (ps_clk),
        .arst_n_i         (arst_n_i),
        .bus              (crate_bus),
        .bridge_type_i    (bridge_type),
        .link_up_i        (link_up_i),
        .bridge_timeout_o (bridge_timeout),
        .bridge_invalid_o (bridge_invalid),
        .link_req_o       (link_req_o),
        .link_sel_o       (link_sel_o),
        .link_adr_o       (link_adr_o),
        .link_we_o        (link_we_o),
        .link_dat_o       (link_dat_o),
        .link_ack_i       (link_ack_i),
        .link_dat_i       (link_dat_i)
    );

    ////////////////////////////////////////
    // UART 16x baud ticks
    ////////////////////////////////////////

    // Housekeeping, 82/1024 of ps_clk
    baud_tick_gen #(.STEP(HSK_STEP), .WIDTH(HSK_WIDTH)) u_hsk_baud (
        .ps_clk   (ps_clk),
        .arst_n_i (arst_n_i),
        .tick_o   (hsk_16x_o)
    );

    // GPS at 38400 baud
    baud_tick_gen #(.STEP(GPS_STEP), .WIDTH(GPS_WIDTH)) u_gps_baud (
        .ps_clk   (ps_clk),
        .arst_n_i (arst_n_i),
        .tick_o   (gps_16x_o)
    );

endmodule

// File: tb/tb_turf_regs.sv
module tb_turf_regs;

    ////////////////////////////////////////
    // Test constants
    ////////////////////////////////////////

    localparam int          CLK_HALF       = 10;
    localparam int          RESET_CYCLES   = 8;
    localparam int          BRIDGE_TIMEOUT = 64;
    localparam int          HSK_STEP       = 82;
    localparam int          HSK_WIDTH      = 10;
    localparam int          GPS_STEP       = 25;
    localparam int          GPS_WIDTH      = 12;
    localparam logic [3:0]  VER_MAJOR      = 4'd1;
    localparam logic [3:0]  VER_MINOR      = 4'd3;
    localparam logic [7:0]  VER_REV        = 8'h25;
    localparam logic [15:0] FW_DATE        = 16'h5A3C;
    localparam bit          REV_B          = 1'b1;
    // Longest access is a full bridge timeout
    localparam int          ACK_LIMIT      = BRIDGE_TIMEOUT + 8;
    // 4096-cycle GPS window plus the bus tests
    localparam int          MAX_CYCLES     = 6000;

    // ASCII "TURF"
    localparam logic [31:0] IDENT_EXP   = 32'h5455_5246;
    localparam logic [31:0] ERR_WORD    = 32'hDEAD_DEAD;
    // Rev B flag on top of date 0x5A3C, version 1.3 rev 0x25
    localparam logic [31:0] DATEVER_EXP = 32'hDA3C_1325;
    localparam logic [27:0] ADR_IDENT   = 28'h000_0000;
    localparam logic [27:0] ADR_DATEVER = 28'h000_0004;
    localparam logic [27:0] ADR_BTYPE   = 28'h000_0008;
    localparam logic [27:0] ADR_STAT    = 28'h000_000C;

    logic        ps_clk;
    logic        arst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [27:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        link_req_o;
    logic [1:0]  link_sel_o;
    logic [24:0] link_adr_o;
    logic        link_we_o;
    logic [31:0] link_dat_o;
    logic        link_ack_i;
    logic [31:0] link_dat_i;
    logic [3:0]  link_up_i;
    logic        hsk_16x_o;
    logic        gps_16x_o;

    integer      seed = 32'h13610c3b;
    int          mismatch_count = 0;
    int          proto_count = 0;
    int          cycle_count = 0;
    // Links that never answer
    logic [3:0]  mute = 4'b0000;
    // Last request seen by the link model
    int          req_count = 0;
    logic [1:0]  req_sel;
    logic [24:0] req_adr;
    logic        req_we;
    logic [31:0] req_dat;
    logic        baud_done = 1'b0;

    turf_regs_top #(
        .VER_MAJOR      (VER_MAJOR),
        .VER_MINOR      (VER_MINOR),
        .VER_REV        (VER_REV),
        .FIRMWARE_DATE  (FW_DATE),
        .REV_B          (REV_B),
        .BRIDGE_TIMEOUT (BRIDGE_TIMEOUT),
        .HSK_STEP       (HSK_STEP),
        .HSK_WIDTH      (HSK_WIDTH),
        .GPS_STEP       (GPS_STEP),
        .GPS_WIDTH      (GPS_WIDTH)
    ) i_dut (
        .ps_clk     (ps_clk),
        .arst_n_i   (arst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .link_req_o (link_req_o),
        .link_sel_o (link_sel_o),
        .link_adr_o (link_adr_o),
        .link_we_o  (link_we_o),
        .link_dat_o (link_dat_o),
        .link_ack_i (link_ack_i),
        .link_dat_i (link_dat_i),
        .link_up_i  (link_up_i),
        .hsk_16x_o  (hsk_16x_o),
        .gps_16x_o  (gps_16x_o)
    );

    initial begin
        ps_clk = 1'b0;
        forever #CLK_HALF ps_clk = ~ps_clk;
    end

    // Run limit
    initial begin : run_limit
        while (cycle_count < MAX_CYCLES) begin
            @(posedge ps_clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("errors: %0d mismatches, %0d protocol", mismatch_count, proto_count);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////
    // Checks and bus helpers
    ////////////////////////////////////////

    // Remote data is the address tagged with the link number
    function automatic logic [31:0] link_resp(input logic [1:0] link, input logic [24:0] radr);
        return {link, 5'b0, radr};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        end
    endtask

    // One WISHBONE cycle, held through the ack cycle
    task automatic bus_access(input logic we, input logic [27:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int waited;
        rdat   = '0;
        waited = 0;
        @(negedge ps_clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        do begin
            @(negedge ps_clk);
            waited++;
        end while (!wb_ack_o && waited < ACK_LIMIT);
        assert (wb_ack_o) else begin
            proto_count++;
            $display("no ack for access to 0x%07h within %0d cycles", adr, ACK_LIMIT);
        end
        rdat = wb_dat_o;
        @(negedge ps_clk);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_read(input logic [27:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'h0, rdat);
    endtask

    task automatic bus_write(input logic [27:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    // Crate access plus the link request it should or should not cause
    task automatic crate_access(input logic we, input logic [1:0] link, input logic [24:0] radr,
                                input logic [31:0] wdat, input logic exp_req,
                                input logic [31:0] exp_rdat);
        int          reqs_before;
        logic [31:0] rdat;
        reqs_before = req_count;
        bus_access(we, {1'b1, link, radr}, wdat, rdat);
        check_value("link_req_o count", reqs_before + int'(exp_req), req_count);
        if (exp_req) begin
            check_value("link_sel_o", link, req_sel);
            check_value("link_adr_o", radr, req_adr);
            check_value("link_we_o", we, req_we);
            if (we) begin
                check_value("link_dat_o", wdat, req_dat);
            end
        end
        if (!we) begin
            check_value("wb_dat_o", exp_rdat, rdat);
        end
    endtask

    // Read the sticky flags, clear them by W1C, read zero back
    task automatic status_clear(input logic [7:0] exp);
        logic [31:0] rdat;
        bus_read(ADR_STAT, rdat);
        check_value("bridge status", {24'h0, exp}, rdat);
        bus_write(ADR_STAT, {24'h0, exp});
        bus_read(ADR_STAT, rdat);
        check_value("bridge status after clear", 32'h0, rdat);
    endtask

    ////////////////////////////////////////
    // Remote link model
    ////////////////////////////////////////

    initial begin : link_model
        int delay;
        forever begin
            @(negedge ps_clk);
            if (link_req_o) begin
                req_count++;
                req_sel = link_sel_o;
                req_adr = link_adr_o;
                req_we  = link_we_o;
                req_dat = link_dat_o;
                // Muted link drops the request
                if (!mute[link_sel_o]) begin
                    delay = 1 + ($unsigned($random(seed)) % 20);
                    repeat (delay - 1) @(negedge ps_clk);
                    link_dat_i = link_resp(req_sel, req_adr);
                    link_ack_i = 1'b1;
                    @(negedge ps_clk);
                    link_ack_i = 1'b0;
                end
            end
        end
    end

    // Baud ticks counted from reset release
    initial begin : baud_count
        int hsk_ticks;
        int gps_ticks;
        hsk_ticks = 0;
        gps_ticks = 0;
        @(negedge arst_n_i);
        @(posedge arst_n_i);
        for (int n = 1; n <= 2 ** GPS_WIDTH; n++) begin
            @(negedge ps_clk);
            if (n <= 2 ** HSK_WIDTH && hsk_16x_o) begin
                hsk_ticks++;
            end
            if (gps_16x_o) begin
                gps_ticks++;
            end
        end
        check_value("hsk_16x_o tick count", HSK_STEP, hsk_ticks);
        check_value("gps_16x_o tick count", GPS_STEP, gps_ticks);
        baud_done = 1'b1;
    end

    ////////////////////////////////////////
    // Protocol assertions
    ////////////////////////////////////////

    a_reset_quiet: assert property (
        @(posedge ps_clk) !arst_n_i |-> !wb_ack_o && !link_req_o && !hsk_16x_o && !gps_16x_o
    ) else begin
        proto_count++;
        $display("outputs active during reset at %0t", $time);
    end

    a_ack_single: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i) wb_ack_o |=> !wb_ack_o
    ) else begin
        proto_count++;
        $display("ack lasted more than one cycle at %0t", $time);
    end

    a_req_single: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i) link_req_o |=> !link_req_o
    ) else begin
        proto_count++;
        $display("link request lasted more than one cycle at %0t", $time);
    end

    // Only crate cycles reach a link
    a_req_in_crate: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i) link_req_o |-> wb_cyc_i && wb_adr_i[27]
    ) else begin
        proto_count++;
        $display("link request outside a crate access at %0t", $time);
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] rdat;
        logic [1:0]  link;
        logic [24:0] radr;
        logic [31:0] wdat;
        logic        we;
        arst_n_i   = 1'b1;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        link_ack_i = 1'b0;
        link_dat_i = '0;
        // Link 2 down, the rest up
        link_up_i  = 4'b1011;
        #1;
        arst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge ps_clk);
        arst_n_i = 1'b1;

        // Idle state after reset
        check_value("wb_ack_o", 32'h0, wb_ack_o);
        check_value("link_req_o", 32'h0, link_req_o);
        bus_read(ADR_STAT, rdat);
        check_value("bridge status", 32'h0, rdat);

        // ID words and the dummy space
        bus_read(ADR_IDENT, rdat);
        check_value("ident", IDENT_EXP, rdat);
        bus_read(ADR_DATEVER, rdat);
        check_value("date/version", DATEVER_EXP, rdat);
        bus_read(28'h000_4000, rdat);
        check_value("dummy read", 32'h0, rdat);
        bus_write(28'h400_0010, 32'h1234_5678);
        bus_read(28'h400_0010, rdat);
        check_value("dummy read", 32'h0, rdat);

        // Links 0..2 link bridges, link 3 type 2
        bus_write(ADR_BTYPE, 32'h0000_0095);
        bus_read(ADR_BTYPE, rdat);
        check_value("bridge type", 32'h0000_0095, rdat);

        crate_access(1'b1, 2'd0, 25'h0123456, 32'hCAFE_0001, 1'b1, 32'h0);
        crate_access(1'b0, 2'd1, 25'h1ABCDE0, 32'h0, 1'b1, link_resp(2'd1, 25'h1ABCDE0));
        repeat (6) begin
            link = 2'($unsigned($random(seed)) % 2);
            radr = 25'($random(seed));
            wdat = $random(seed);
            we   = 1'($random(seed));
            crate_access(we, link, radr, wdat, 1'b1, link_resp(link, radr));
        end

        // Valid type but the link is down
        crate_access(1'b0, 2'd2, 25'h0000040, 32'h0, 1'b0, ERR_WORD);
        status_clear(8'h40);

        // Link 3 up with each unimplemented type
        for (int t = 0; t < 4; t++) begin
            if (t != 1) begin
                bus_write(ADR_BTYPE, {24'h0, 2'(t), 6'b01_01_01});
                crate_access(1'b0, 2'd3, 25'h1000000 + 25'(t), 32'h0, 1'b0, ERR_WORD);
                status_clear(8'h80);
            end
        end

        // Muted link runs into the timeout
        mute = 4'b0001;
        crate_access(1'b0, 2'd0, 25'h0000100, 32'h0, 1'b1, ERR_WORD);
        status_clear(8'h01);
        mute = 4'b0000;
        crate_access(1'b0, 2'd0, 25'h0000104, 32'h0, 1'b1, link_resp(2'd0, 25'h0000104));

        wait (baud_done);
        @(negedge ps_clk);
        $display("errors: %0d mismatches, %0d protocol", mismatch_count, proto_count);
        if (mismatch_count == 0 && proto_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
design/turf_pkg.sv
design/wb_if.sv
design/baud_tick_gen.sv
design/reg_intercon.sv
design/turf_id_ctrl.sv
design/crate_bridge.sv
design/turf_regs_top.sv
tb/tb_turf_regs.sv
